// ==== Makefile ====
SOURCES := $(shell cat list.f)

obj_dir/Vtb_top: list.f $(SOURCES)
	verilator --binary --assert -Wno-fatal --top-module tb_top -f list.f -o Vtb_top

run: obj_dir/Vtb_top
	@./obj_dir/Vtb_top > sim.log 2>&1; status=$$?; cat sim.log; \
	test $$status -eq 0 && ! grep -qF '*** TEST FAILED ***' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// ==== dv/tb_checker.sv ====
// --------------------------------------------------
// Scoreboard for the legalizer testbench. Mirrors the
// register writes, predicts every chunk of a started
// transfer and compares the DUT outputs against it
// --------------------------------------------------
`timescale 1ns/1ps

module tb_checker #(
    parameter int unsigned OffsetWidth   = 2,
    parameter int unsigned PageAddrWidth = 4
) (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 reg_wr_i,
    input  logic [2:0]           reg_addr_i,
    input  logic [31:0]          reg_wdata_i,
    input  logic [31:0]          reg_rdata_i,
    input  logic                 stall_i,
    input  logic                 chunk_valid_i,
    input  dma_types_pkg::addr_t chunk_addr_i,
    input  dma_types_pkg::len_t  chunk_bytes_i,
    input  logic                 done_i,
    output int unsigned          error_count_o
);

    // Model of the register contents
    dma_types_pkg::addr_t      src_addr_m;
    dma_types_pkg::total_len_t length_m;
    logic                      busy_m;
    int unsigned               chunks_m;
    // Predicted chunks of the running transfer, oldest first
    dma_types_pkg::addr_t      exp_addr_q[$];
    int unsigned               exp_size_q[$];
    dma_types_pkg::addr_t      walk_addr;
    int unsigned               walk_left;
    int unsigned               walk_size;
    int unsigned               chunk_errors = 0;
    int unsigned               other_errors = 0;
    int unsigned               tests_run = 0;
    int unsigned               tests_failed = 0;
    int unsigned               errors_before = 0;
    string                     test_name = "reset";

    assign error_count_o = chunk_errors + other_errors;

    // Largest power of two within the word remainder (or one burst) and the bytes left
    function automatic int unsigned chunk_size(input dma_types_pkg::addr_t addr,
                                               input int unsigned left);
        int unsigned cap;
        int unsigned size;
        cap = 1 << PageAddrWidth;
        if (addr[OffsetWidth-1:0] != '0) begin
            cap = (1 << OffsetWidth) - int'(addr[OffsetWidth-1:0]);
        end
        if (left < cap) begin
            cap = left;
        end
        size = 1;
        while (size * 2 <= cap) begin
            size = size * 2;
        end
        return size;
    endfunction

    always @(posedge clk_i) begin
        if (rst_i) begin
            src_addr_m = '0;
            length_m   = '0;
            busy_m     = 1'b0;
            chunks_m   = 0;
            exp_addr_q.delete();
            exp_size_q.delete();
        end else begin
            if (chunk_valid_i) begin
                if (stall_i) begin
                    $display("Error in %s: chunk_valid_o high while stalled", test_name);
                    chunk_errors++;
                end
                if (exp_addr_q.size() == 0) begin
                    $display("Error in %s: chunk at %h with no transfer running",
                             test_name, chunk_addr_i);
                    chunk_errors++;
                end else begin
                    walk_addr = exp_addr_q.pop_front();
                    walk_size = exp_size_q.pop_front();
                    if (chunk_addr_i !== walk_addr) begin
                        $display("Fail %s chunk address expected %h actual %h",
                                 test_name, walk_addr, chunk_addr_i);
                        chunk_errors++;
                    end
                    if (chunk_bytes_i !== dma_types_pkg::len_t'(walk_size)) begin
                        $display("Fail %s chunk size expected %0d actual %0d",
                                 test_name, walk_size, chunk_bytes_i);
                        chunk_errors++;
                    end
                end
            end
            if (reg_wr_i) begin
                case (reg_addr_i)
                    dma_regs_pkg::REG_SRC_ADDR: src_addr_m = reg_wdata_i;
                    dma_regs_pkg::REG_LENGTH:
                        length_m = reg_wdata_i[dma_types_pkg::TotalLenWidth-1:0];
                    dma_regs_pkg::REG_CTRL: begin
                        // Start only from idle with a nonzero length, walk the whole transfer
                        if (reg_wdata_i[dma_regs_pkg::CTRL_START_BIT] && !busy_m
                                && length_m != '0) begin
                            busy_m    = 1'b1;
                            chunks_m  = 0;
                            walk_addr = src_addr_m;
                            walk_left = length_m;
                            while (walk_left != 0) begin
                                walk_size = chunk_size(walk_addr, walk_left);
                                exp_addr_q.push_back(walk_addr);
                                exp_size_q.push_back(walk_size);
                                walk_addr = walk_addr + walk_size;
                                walk_left = walk_left - walk_size;
                                chunks_m++;
                            end
                        end
                    end
                    default: ;
                endcase
            end
            // Done closes the transfer after the last chunk only
            if (done_i) begin
                if (!busy_m || exp_addr_q.size() != 0) begin
                    $display("Error in %s: done_o out of turn with %0d chunks still due",
                             test_name, exp_addr_q.size());
                    chunk_errors++;
                end
                busy_m = 1'b0;
            end
        end
    end

    task automatic begin_test(input string name);
        test_name     = name;
        errors_before = chunk_errors + other_errors;
    endtask

    task automatic end_test();
        int unsigned errs;
        errs = chunk_errors + other_errors - errors_before;
        tests_run++;
        if (errs == 0) begin
            $display("Test %s ok", test_name);
        end else begin
            tests_failed++;
            $display("Test %s has %0d errors", test_name, errs);
        end
    endtask

    task automatic report_error(input string what);
        $display("Error in %s: %s", test_name, what);
        other_errors++;
    endtask

    // Compare a register readback with the model
    task automatic compare_read(input logic [2:0] offset);
        logic [31:0] expected;
        expected = '0;
        case (offset)
            dma_regs_pkg::REG_SRC_ADDR: expected = src_addr_m;
            dma_regs_pkg::REG_LENGTH:   expected = 32'(length_m);
            dma_regs_pkg::REG_STATUS:   expected[dma_regs_pkg::STATUS_BUSY_BIT] = busy_m;
            dma_regs_pkg::REG_CHUNKS:   expected = chunks_m;
            default:                    expected = '0;
        endcase
        if (reg_rdata_i !== expected) begin
            $display("Fail %s register %0d expected %h actual %h",
                     test_name, offset, expected, reg_rdata_i);
            other_errors++;
        end
    endtask

    task automatic report_counts();
        $display("Tests run %0d, failed %0d, errors %0d",
                 tests_run, tests_failed, chunk_errors + other_errors);
    endtask

endmodule

// ==== dv/tb_top.sv ====
// --------------------------------------------------
// Testbench top for the DMA legalizer. Programs random
// transfers and stall patterns on falling edges while
// tb_checker compares every chunk and readback
// --------------------------------------------------
`timescale 1ns/1ps

module tb_top;

    localparam int unsigned OffsetWidth   = 2;
    localparam int unsigned PageAddrWidth = 4;

    logic                 clk_i;
    logic                 rst_i;
    logic                 reg_wr_i;
    logic [2:0]           reg_addr_i;
    logic [31:0]          reg_wdata_i;
    logic                 stall_i;
    logic [31:0]          reg_rdata_o;
    logic                 chunk_valid_o;
    dma_types_pkg::addr_t chunk_addr_o;
    dma_types_pkg::len_t  chunk_bytes_o;
    logic                 done_o;
    logic [31:0]          rng_state;
    int unsigned          total_errors;

    // Cycle allowance for one transfer with room for heavy stalling
    function automatic int unsigned transfer_budget(input int unsigned len);
        return ((len >> PageAddrWidth) + 16) * 8;
    endfunction

    // Longest case of every test doubled as margin
    localparam int unsigned TimeoutCycles = 2 * (6 * transfer_budget(1024)
        + 6 * transfer_budget(256) + 3 * transfer_budget(8192)
        + 4 * transfer_budget(512) + transfer_budget(256) + 400);

    legalizer_top #(
        .OffsetWidth   (OffsetWidth),
        .PageAddrWidth (PageAddrWidth)
    ) legalizer_top_inst (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .reg_wr_i      (reg_wr_i),
        .reg_addr_i    (reg_addr_i),
        .reg_wdata_i   (reg_wdata_i),
        .stall_i       (stall_i),
        .reg_rdata_o   (reg_rdata_o),
        .chunk_valid_o (chunk_valid_o),
        .chunk_addr_o  (chunk_addr_o),
        .chunk_bytes_o (chunk_bytes_o),
        .done_o        (done_o)
    );

    tb_checker #(
        .OffsetWidth   (OffsetWidth),
        .PageAddrWidth (PageAddrWidth)
    ) checker_inst (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .reg_wr_i      (reg_wr_i),
        .reg_addr_i    (reg_addr_i),
        .reg_wdata_i   (reg_wdata_i),
        .reg_rdata_i   (reg_rdata_o),
        .stall_i       (stall_i),
        .chunk_valid_i (chunk_valid_o),
        .chunk_addr_i  (chunk_addr_o),
        .chunk_bytes_i (chunk_bytes_o),
        .done_i        (done_o),
        .error_count_o (total_errors)
    );

    initial begin
        clk_i = 1'b0;
        forever begin
            #4 clk_i = ~clk_i;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] draw_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    task automatic write_reg(input logic [2:0] offset, input logic [31:0] value);
        @(negedge clk_i);
        reg_wr_i    = 1'b1;
        reg_addr_i  = offset;
        reg_wdata_i = value;
        @(negedge clk_i);
        reg_wr_i    = 1'b0;
    endtask

    // Readback is combinational and compared a full cycle after the address
    task automatic check_reg(input logic [2:0] offset);
        @(negedge clk_i);
        reg_addr_i = offset;
        @(negedge clk_i);
        checker_inst.compare_read(offset);
    endtask

    // Poll done_o each falling edge, stall at random on request
    task automatic wait_done(input bit stall_mode, input int unsigned limit);
        int unsigned cycles;
        logic        seen;
        logic [31:0] r;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < limit) begin
            @(negedge clk_i);
            seen    = done_o;
            r       = draw_random();
            stall_i = stall_mode && !seen && r[0];
            cycles++;
        end
        stall_i = 1'b0;
        if (!seen) begin
            checker_inst.report_error($sformatf("done_o missing after %0d cycles", limit));
        end
    endtask

    task automatic run_transfer(input logic [31:0] addr, input int unsigned len,
                                input bit stall_mode);
        write_reg(dma_regs_pkg::REG_SRC_ADDR, addr);
        write_reg(dma_regs_pkg::REG_LENGTH, len);
        write_reg(dma_regs_pkg::REG_CTRL, 32'(1) << dma_regs_pkg::CTRL_START_BIT);
        wait_done(stall_mode, transfer_budget(len));
    endtask

    // Kind 0 aligned, 1 misaligned, 2 beyond len_t, 3 stalled
    task automatic run_random_test(input string name, input int unsigned count,
                                   input int unsigned kind);
        logic [31:0] addr;
        logic [31:0] len;
        checker_inst.begin_test(name);
        repeat (count) begin
            addr = draw_random();
            len  = draw_random();
            case (kind)
                0: begin
                    addr[OffsetWidth-1:0] = '0;
                    len = 1 + len % 1024;
                end
                1: begin
                    if (addr[OffsetWidth-1:0] == '0) begin
                        addr[0] = 1'b1;
                    end
                    len = 1 + len % 256;
                end
                2: len = 4096 + len % 4096;
                default: len = 1 + len % 512;
            endcase
            run_transfer(addr, len, kind == 3);
        end
        checker_inst.end_test();
    endtask

    task automatic run_register_test();
        checker_inst.begin_test("registers");
        write_reg(dma_regs_pkg::REG_SRC_ADDR, draw_random());
        check_reg(dma_regs_pkg::REG_SRC_ADDR);
        write_reg(dma_regs_pkg::REG_LENGTH, draw_random());
        check_reg(dma_regs_pkg::REG_LENGTH);
        write_reg(dma_regs_pkg::REG_LENGTH, 256);
        write_reg(dma_regs_pkg::REG_CTRL, 1);
        // Second start lands while the engine is busy
        write_reg(dma_regs_pkg::REG_CTRL, 1);
        // Busy reads back high while the transfer runs
        check_reg(dma_regs_pkg::REG_STATUS);
        wait_done(1'b0, transfer_budget(256));
        check_reg(dma_regs_pkg::REG_CHUNKS);
        check_reg(dma_regs_pkg::REG_STATUS);
        // Zero length start must stay silent
        write_reg(dma_regs_pkg::REG_LENGTH, 0);
        write_reg(dma_regs_pkg::REG_CTRL, 1);
        repeat (20) @(negedge clk_i);
        check_reg(dma_regs_pkg::REG_STATUS);
        check_reg(dma_regs_pkg::REG_CHUNKS);
        checker_inst.end_test();
    endtask

    initial begin
        rng_state   = 32'd81;
        rst_i       = 1'b1;
        reg_wr_i    = 1'b0;
        reg_addr_i  = '0;
        reg_wdata_i = '0;
        stall_i     = 1'b0;
        repeat (10) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;
        run_random_test("aligned", 6, 0);
        run_random_test("misaligned", 6, 1);
        run_random_test("long", 3, 2);
        run_random_test("stall", 4, 3);
        run_register_test();
        checker_inst.report_counts();
        if (total_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // Watchdog over the whole run
    initial begin
        repeat (TimeoutCycles) @(posedge clk_i);
        $display("Timeout: run still going after %0d cycles", TimeoutCycles);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// ==== list.f ====
logic/dma_types_pkg.sv
logic/dma_regs_pkg.sv
logic/legalizer_req_if.sv
logic/legalizer_cfg_regs.sv
logic/legalizer_pow2_splitter.sv
logic/legalizer_core.sv
logic/legalizer_top.sv
dv/tb_checker.sv
dv/tb_top.sv

// ==== logic/dma_regs_pkg.sv ====
// -----------------------------------------------
// Register map of the legalizer register block.
// Offsets, access decode enum and control bits,
// shared by the RTL and the testbench driver
// -----------------------------------------------

package dma_regs_pkg;

    // Register offsets on the 3-bit register address
    localparam logic [2:0] REG_SRC_ADDR = 3'd0;
    localparam logic [2:0] REG_LENGTH   = 3'd1;
    localparam logic [2:0] REG_CTRL     = 3'd2;
    localparam logic [2:0] REG_STATUS   = 3'd3;
    localparam logic [2:0] REG_CHUNKS   = 3'd4;

    // Decoded register access
    typedef enum logic [1:0] {
        OP_NONE,
        OP_WRITE,
        OP_READ
    } reg_op_e;

    // Start request in REG_CTRL
    localparam int unsigned CTRL_START_BIT = 0;
    // Engine busy flag in REG_STATUS
    localparam int unsigned STATUS_BUSY_BIT = 0;

endpackage

// ==== logic/dma_types_pkg.sv ====
// -----------------------------------------------
// Address, length and count types for the DMA
// legalizer, together with the engine state enum.
// Referenced by scoped name from RTL and testbench
// -----------------------------------------------

package dma_types_pkg;

    // Byte address width
    localparam int unsigned AddrWidth = 32;
    // Length seen by the splitter, one chunk never exceeds it
    localparam int unsigned LenWidth = 12;
    // Full transfer byte count as written by software
    localparam int unsigned TotalLenWidth = 20;

    typedef logic [AddrWidth-1:0]     addr_t;
    typedef logic [LenWidth-1:0]      len_t;
    typedef logic [TotalLenWidth-1:0] total_len_t;

    // Splitting engine states
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SPLIT,
        ST_DONE
    } engine_state_e;

endpackage

// ==== logic/legalizer_cfg_regs.sv ====
// -----------------------------------------------
// Register block of the legalizer. Holds source
// address and length, issues start on a control
// write and reports busy and the chunk count
// -----------------------------------------------
`timescale 1ns/1ps

module legalizer_cfg_regs (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 reg_wr_i,
    input  logic [2:0]           reg_addr_i,
    input  logic [31:0]          reg_wdata_i,
    output logic [31:0]          reg_rdata_o,
    legalizer_req_if.cfg_mp      req
);

    dma_regs_pkg::reg_op_e     reg_op;
    dma_types_pkg::addr_t      src_addr_q;
    dma_types_pkg::total_len_t length_q;
    dma_types_pkg::total_len_t chunk_cnt_q;
    logic                      start_q;
    logic                      start_ok;

    // Offsets past REG_CHUNKS decode to no access
    always_comb begin
        if (reg_addr_i > dma_regs_pkg::REG_CHUNKS) begin
            reg_op = dma_regs_pkg::OP_NONE;
        end else if (reg_wr_i) begin
            reg_op = dma_regs_pkg::OP_WRITE;
        end else begin
            reg_op = dma_regs_pkg::OP_READ;
        end
    end

    // Start only from an idle engine with a nonzero length
    // A start already in flight also blocks a second one
    assign start_ok = (reg_op == dma_regs_pkg::OP_WRITE)
                    && (reg_addr_i == dma_regs_pkg::REG_CTRL)
                    && reg_wdata_i[dma_regs_pkg::CTRL_START_BIT]
                    && !req.busy && !start_q && (length_q != '0);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            src_addr_q  <= '0;
            length_q    <= '0;
            chunk_cnt_q <= '0;
            start_q     <= 1'b0;
        end else begin
            start_q <= start_ok;
            if (reg_op == dma_regs_pkg::OP_WRITE) begin
                if (reg_addr_i == dma_regs_pkg::REG_SRC_ADDR) begin
                    src_addr_q <= reg_wdata_i;
                end
                if (reg_addr_i == dma_regs_pkg::REG_LENGTH) begin
                    length_q <= reg_wdata_i[dma_types_pkg::TotalLenWidth-1:0];
                end
            end
            // New transfer restarts the count
            if (start_q) begin
                chunk_cnt_q <= '0;
            end else if (req.chunk_done) begin
                chunk_cnt_q <= chunk_cnt_q + 1'b1;
            end
        end
    end

    assign req.start     = start_q;
    assign req.src_addr  = src_addr_q;
    assign req.total_len = length_q;

    // Combinational readback, REG_CTRL reads as zero
    always_comb begin
        reg_rdata_o = '0;
        if (reg_op != dma_regs_pkg::OP_NONE) begin
            case (reg_addr_i)
                dma_regs_pkg::REG_SRC_ADDR: reg_rdata_o = src_addr_q;
                dma_regs_pkg::REG_LENGTH:   reg_rdata_o = 32'(length_q);
                dma_regs_pkg::REG_STATUS:   reg_rdata_o[dma_regs_pkg::STATUS_BUSY_BIT] = req.busy;
                dma_regs_pkg::REG_CHUNKS:   reg_rdata_o = 32'(chunk_cnt_q);
                default:                    reg_rdata_o = '0;
            endcase
        end
    end

    // Engine busy comes back from the core, a start must never overlap it
    assert property (@(posedge clk_i) disable iff (rst_i)
        $rose(req.start) |-> !req.busy);

endmodule

// ==== logic/legalizer_core.sv ====
// -----------------------------------------------
// Splitting engine. Latches a request on start and
// emits one legal chunk per unstalled cycle until
// the remaining count is zero, then pulses done
// -----------------------------------------------
`timescale 1ns/1ps

module legalizer_core #(
    parameter int unsigned OffsetWidth   = 2,
    parameter int unsigned PageAddrWidth = 4
) (
    input  logic                 clk_i,
    input  logic                 rst_i,
    // Consumer back-pressure level
    input  logic                 stall_i,
    output logic                 chunk_valid_o,
    output dma_types_pkg::addr_t chunk_addr_o,
    output dma_types_pkg::len_t  chunk_bytes_o,
    output logic                 done_o,
    legalizer_req_if.eng_mp      req
);

    localparam int unsigned LenWidth      = dma_types_pkg::LenWidth;
    localparam int unsigned TotalLenWidth = dma_types_pkg::TotalLenWidth;

    dma_types_pkg::engine_state_e state_q;
    dma_types_pkg::addr_t         addr_q;
    dma_types_pkg::total_len_t    remain_q;
    dma_types_pkg::len_t          remain_clip;
    dma_types_pkg::len_t          split_bytes;
    dma_types_pkg::total_len_t    step;
    logic                         remain_larger;

    // Upper bits set means the remainder does not fit in len_t
    assign remain_larger = |remain_q[TotalLenWidth-1:LenWidth];
    assign remain_clip   = remain_larger ? '1 : remain_q[LenWidth-1:0];

    legalizer_pow2_splitter #(
        .OffsetWidth   (OffsetWidth),
        .PageAddrWidth (PageAddrWidth)
    ) splitter_inst (
        .addr_i              (addr_q),
        .length_i            (remain_clip),
        .length_larger_i     (remain_larger),
        .bytes_to_transfer_o (split_bytes)
    );

    assign step = dma_types_pkg::total_len_t'(split_bytes);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q  <= dma_types_pkg::ST_IDLE;
            addr_q   <= '0;
            remain_q <= '0;
        end else begin
            case (state_q)
                dma_types_pkg::ST_IDLE: begin
                    // Register block already checked busy and length
                    if (req.start) begin
                        addr_q   <= req.src_addr;
                        remain_q <= req.total_len;
                        state_q  <= dma_types_pkg::ST_SPLIT;
                    end
                end
                dma_types_pkg::ST_SPLIT: begin
                    // Everything holds while stalled
                    if (!stall_i) begin
                        addr_q   <= addr_q + dma_types_pkg::addr_t'(split_bytes);
                        remain_q <= remain_q - step;
                        if (remain_q == step) begin
                            state_q <= dma_types_pkg::ST_DONE;
                        end
                    end
                end
                dma_types_pkg::ST_DONE: begin
                    state_q <= dma_types_pkg::ST_IDLE;
                end
                default: begin
                    state_q <= dma_types_pkg::ST_IDLE;
                end
            endcase
        end
    end

    assign chunk_valid_o  = (state_q == dma_types_pkg::ST_SPLIT) && !stall_i;
    assign chunk_addr_o   = addr_q;
    assign chunk_bytes_o  = split_bytes;
    assign done_o         = (state_q == dma_types_pkg::ST_DONE);
    // Busy covers the done cycle too
    assign req.busy       = (state_q != dma_types_pkg::ST_IDLE);
    assign req.chunk_done = chunk_valid_o;

    // Splitter output seen by the consumer is a legal size
    assert property (@(posedge clk_i) disable iff (rst_i)
        chunk_valid_o |-> $onehot(chunk_bytes_o));

    // A chunk never overruns the transfer
    assert property (@(posedge clk_i) disable iff (rst_i)
        chunk_valid_o |-> (dma_types_pkg::total_len_t'(chunk_bytes_o) <= remain_q));

    // No chunk escapes from idle or done
    assert property (@(posedge clk_i) disable iff (rst_i)
        chunk_valid_o |-> (state_q == dma_types_pkg::ST_SPLIT));

endmodule

// ==== logic/legalizer_pow2_splitter.sv ====
// -----------------------------------------------
// Chunk size selection for the legalizer engine.
// Pure combinational, fed with the current address
// and the remaining length every cycle
// -----------------------------------------------
`timescale 1ns/1ps

module legalizer_pow2_splitter #(
    parameter int unsigned OffsetWidth   = 2,
    parameter int unsigned PageAddrWidth = 4
) (
    input  dma_types_pkg::addr_t addr_i,
    // Remaining length, saturated by the caller
    input  dma_types_pkg::len_t  length_i,
    // Remaining length does not fit in len_t
    input  logic                 length_larger_i,
    output dma_types_pkg::len_t  bytes_to_transfer_o
);

    // Bus word size and full burst size
    localparam logic [OffsetWidth:0] WordBytes = {1'b1, {OffsetWidth{1'b0}}};
    localparam dma_types_pkg::len_t  FullBurst = dma_types_pkg::len_t'(1) << PageAddrWidth;

    logic [OffsetWidth:0] word_left;
    logic [OffsetWidth:0] sub_cap;
    logic                 aligned;
    dma_types_pkg::len_t  sub_bytes;
    dma_types_pkg::len_t  burst_bytes;

    // Bytes until the next word boundary
    assign word_left = WordBytes - {1'b0, addr_i[OffsetWidth-1:0]};
    assign aligned   = (addr_i[OffsetWidth-1:0] == '0);

    // Limit by the transfer too, unless the remainder is huge
    assign sub_cap = (!length_larger_i && dma_types_pkg::len_t'(word_left) > length_i)
                   ? length_i[OffsetWidth:0] : word_left;

    // Highest set bit of the cap gives the subword size
    always_comb begin
        sub_bytes = '0;
        for (int i = 0; i <= OffsetWidth; i++) begin
            if (sub_cap[i]) begin
                sub_bytes = dma_types_pkg::len_t'(1) << i;
            end
        end
    end

    // Largest power of two in length, saturating at one burst
    always_comb begin
        burst_bytes = '0;
        for (int i = 0; i <= PageAddrWidth; i++) begin
            if (length_i[i]) begin
                burst_bytes = dma_types_pkg::len_t'(1) << i;
            end
        end
        if (length_i >= FullBurst) begin
            burst_bytes = FullBurst;
        end
    end

    // Misaligned goes subword first, aligned goes burst
    always_comb begin
        if (!aligned) begin
            bytes_to_transfer_o = sub_bytes;
        end else if (length_larger_i) begin
            bytes_to_transfer_o = FullBurst;
        end else begin
            bytes_to_transfer_o = burst_bytes;
        end
    end

    // Subword and burst paths together stay within one burst
    always_comb begin
        assert (bytes_to_transfer_o <= FullBurst);
    end

endmodule

// ==== logic/legalizer_req_if.sv ====
// -----------------------------------------------
// Transfer request from the register block to the
// splitting engine, with busy and per-chunk pulses
// travelling back the other way
// -----------------------------------------------
`timescale 1ns/1ps

interface legalizer_req_if;

    // Single cycle start strobe
    logic                      start;
    // Latched by the engine on start
    dma_types_pkg::addr_t      src_addr;
    dma_types_pkg::total_len_t total_len;
    // High from the cycle after start until the engine is idle again
    logic                      busy;
    // One pulse per emitted chunk
    logic                      chunk_done;

    // Register block side
    modport cfg_mp (output start, src_addr, total_len, input busy, chunk_done);
    // Engine side
    modport eng_mp (input start, src_addr, total_len, output busy, chunk_done);

endinterface

// ==== logic/legalizer_top.sv ====
// -----------------------------------------------
// Top level of the DMA transfer legalizer. Ties the
// register block to the splitting engine and sets
// word and burst geometry for both
// -----------------------------------------------
`timescale 1ns/1ps

module legalizer_top #(
    // Bus word of 2**OffsetWidth bytes
    parameter int unsigned OffsetWidth   = 2,
    // Full burst of 2**PageAddrWidth bytes, below LenWidth
    parameter int unsigned PageAddrWidth = 4
) (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 reg_wr_i,
    input  logic [2:0]           reg_addr_i,
    input  logic [31:0]          reg_wdata_i,
    input  logic                 stall_i,
    output logic [31:0]          reg_rdata_o,
    output logic                 chunk_valid_o,
    output dma_types_pkg::addr_t chunk_addr_o,
    output dma_types_pkg::len_t  chunk_bytes_o,
    output logic                 done_o
);

    // Request path between register block and engine
    legalizer_req_if req_if ();

    legalizer_cfg_regs cfg_regs_inst (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .reg_wr_i    (reg_wr_i),
        .reg_addr_i  (reg_addr_i),
        .reg_wdata_i (reg_wdata_i),
        .reg_rdata_o (reg_rdata_o),
        .req         (req_if.cfg_mp)
    );

    legalizer_core #(
        .OffsetWidth   (OffsetWidth),
        .PageAddrWidth (PageAddrWidth)
    ) core_inst (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .stall_i       (stall_i),
        .chunk_valid_o (chunk_valid_o),
        .chunk_addr_o  (chunk_addr_o),
        .chunk_bytes_o (chunk_bytes_o),
        .done_o        (done_o),
        .req           (req_if.eng_mp)
    );

endmodule
